/* Makefile */
# Verilator flow for xpu_lite, default target builds and runs the testbench

TOP := xpu_lite_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timescale 1ns/1ps -f xpu_lite.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Regression failed" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Regression passed" sim.log || (echo "no pass message in log"; exit 1)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f xpu_lite.f --top-module xpu_lite

clean:
	rm -rf obj_dir sim.log

/* hw/edge_to_flip.sv */
// activity led driver, flips its output once per rising edge of the event input
module edge_to_flip (
  input  logic clk,
  input  logic rst_n_i,
  input  logic data_i,
  output logic flip_o
);

  logic data_d; // last sampled input

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      data_d <= 1'b0;
      flip_o <= 1'b0;
    end else begin
      data_d <= data_i;
      if (data_i && !data_d) begin
        flip_o <= ~flip_o;
      end
    end
  end

endmodule

/* hw/field_capture.sv */
// grabs one little-endian header field at a fixed byte offset, used once per field by the parser
module field_capture
  import xpu_pkg::*;
#(
  parameter type    field_t = mac_addr_t,
  parameter integer OFS     = 0
)(
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        byte_in_strobe_i,
  input  logic [7:0]  byte_i,
  input  logic [15:0] byte_count_i,
  output field_t      field_o,
  output logic        field_valid_o
);

  localparam int W = $bits(field_t);
  localparam logic [15:0] FIRST = 16'(OFS);
  localparam logic [15:0] LAST  = 16'(OFS + W / 8 - 1);

  logic [W-9:0] shift_q; // earlier bytes of the field, oldest at the bottom
  logic         in_field;
  logic         last_byte;

  assign in_field  = byte_in_strobe_i && (byte_count_i >= FIRST) && (byte_count_i <= LAST);
  assign last_byte = byte_in_strobe_i && (byte_count_i == LAST);

  always_ff @(posedge clk) begin
    if (in_field) shift_q <= {byte_i, shift_q[W-9:8]};
    if (last_byte) field_o <= field_t'({byte_i, shift_q}); // newest byte lands on top
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) field_valid_o <= 1'b0;
    else field_valid_o <= last_byte;
  end

endmodule

/* hw/phy_rx_parse.sv */
// rx mac header parser, pulls fc/duration and three addresses out of the demod byte stream
`include "xpu_lite_macros.svh"

module phy_rx_parse
  import xpu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        byte_in_strobe_i,
  input  logic [7:0]  byte_i,
  input  logic [15:0] byte_count_i,
  input  mac_addr_t   self_mac_addr_i,
  output fc_di_t      fc_di_o,
  output logic        fc_di_valid_o,
  output mac_addr_t   addr1_o,
  output logic        addr1_valid_o,
  output mac_addr_t   addr2_o,
  output logic        addr2_valid_o,
  output mac_addr_t   addr3_o,
  output logic        addr3_valid_o,
  output logic        pkt_for_me_o
);

  localparam logic [15:0] A1_FIRST = 16'(`XPU_ADDR1_OFS);
  localparam logic [15:0] A1_LAST  = 16'(`XPU_ADDR1_OFS + 5);

  logic [15:0] a1_idx;
  logic        a1_first;
  logic        a1_in;
  logic        a1_last;
  logic        a1_byte_hit;
  logic        a1_match_q; // all addr1 bytes so far equal ours

  field_capture #(.field_t(fc_di_t), .OFS(`XPU_FC_OFS)) fc_di_cap (
    .clk(clk), .rst_n_i(rst_n_i), .byte_in_strobe_i(byte_in_strobe_i),
    .byte_i(byte_i), .byte_count_i(byte_count_i),
    .field_o(fc_di_o), .field_valid_o(fc_di_valid_o)
  );

  field_capture #(.field_t(mac_addr_t), .OFS(`XPU_ADDR1_OFS)) addr1_cap (
    .clk(clk), .rst_n_i(rst_n_i), .byte_in_strobe_i(byte_in_strobe_i),
    .byte_i(byte_i), .byte_count_i(byte_count_i),
    .field_o(addr1_o), .field_valid_o(addr1_valid_o)
  );

  field_capture #(.field_t(mac_addr_t), .OFS(`XPU_ADDR2_OFS)) addr2_cap (
    .clk(clk), .rst_n_i(rst_n_i), .byte_in_strobe_i(byte_in_strobe_i),
    .byte_i(byte_i), .byte_count_i(byte_count_i),
    .field_o(addr2_o), .field_valid_o(addr2_valid_o)
  );

  field_capture #(.field_t(mac_addr_t), .OFS(`XPU_ADDR3_OFS)) addr3_cap (
    .clk(clk), .rst_n_i(rst_n_i), .byte_in_strobe_i(byte_in_strobe_i),
    .byte_i(byte_i), .byte_count_i(byte_count_i),
    .field_o(addr3_o), .field_valid_o(addr3_valid_o)
  );

  // compare addr1 against our address byte by byte as it streams in,
  // so the verdict is ready on the same edge that completes addr1
  assign a1_idx      = byte_count_i - A1_FIRST;
  assign a1_first    = byte_in_strobe_i && (byte_count_i == A1_FIRST);
  assign a1_in       = byte_in_strobe_i && (byte_count_i >= A1_FIRST) && (byte_count_i <= A1_LAST);
  assign a1_last     = byte_in_strobe_i && (byte_count_i == A1_LAST);
  assign a1_byte_hit = (byte_i == self_mac_addr_i[{a1_idx[2:0], 3'b000} +: 8]);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      a1_match_q   <= 1'b0;
      pkt_for_me_o <= 1'b0;
    end else begin
      if (a1_in) a1_match_q <= a1_byte_hit & (a1_first | a1_match_q);
      if (a1_last) pkt_for_me_o <= a1_byte_hit & a1_match_q; // held until next addr1
    end
  end

endmodule

/* hw/tsf_timer.sv */
// 64-bit microsecond tsf counter with 1us pulse, loaded by a rising edge of the load control
`include "xpu_lite_macros.svh"

module tsf_timer
  import xpu_pkg::*;
(
  input  logic clk,
  input  logic rst_n_i,
  input  logic tsf_load_ctl_i,
  input  tsf_t tsf_load_val_i,
  output tsf_t tsf_runtime_val_o,
  output logic tsf_pulse_1m_o
);

  localparam int DIV_W = $clog2(`XPU_CLK_PER_US);
  localparam logic [DIV_W-1:0] DIV_TOP = DIV_W'(`XPU_CLK_PER_US - 1);

  logic [DIV_W-1:0] div_cnt_q;
  logic             load_ctl_d;
  logic             load_rise;
  logic             us_tick;

  assign load_rise = tsf_load_ctl_i & ~load_ctl_d;
  assign us_tick   = (div_cnt_q == DIV_TOP); // last clock of the microsecond

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      div_cnt_q         <= '0;
      load_ctl_d        <= 1'b0;
      tsf_runtime_val_o <= '0;
      tsf_pulse_1m_o    <= 1'b0;
    end else begin
      load_ctl_d <= tsf_load_ctl_i;
      if (load_rise) begin
        // new epoch, microsecond phase starts over
        tsf_runtime_val_o <= tsf_load_val_i;
        div_cnt_q         <= '0;
        tsf_pulse_1m_o    <= 1'b0;
      end else begin
        tsf_pulse_1m_o <= us_tick;
        div_cnt_q      <= us_tick ? '0 : div_cnt_q + 1'b1;
        if (us_tick) begin
          tsf_runtime_val_o <= tsf_runtime_val_o + 64'd1;
        end
      end
    end
  end

endmodule

/* hw/xpu_lite.sv */
// top of the lite lower-mac block, joins register bank, tsf timer, rx header parser and leds
`include "xpu_lite_macros.svh"

module xpu_lite
  import xpu_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       reg_wr_en_i,
  input  logic [`XPU_REG_ADDR_W-1:0] reg_addr_i,
  input  reg_data_t                  reg_wdata_i,
  input  logic                       byte_in_strobe_i,
  input  logic [7:0]                 byte_i,
  input  logic [15:0]                byte_count_i,
  input  logic                       pkt_header_valid_i,
  input  logic                       pkt_header_valid_strobe_i,
  input  logic                       demod_is_ongoing_i,
  input  logic                       phy_tx_started_i,
  output reg_data_t                  reg_rdata_o,
  output band_t                      band_o,
  output channel_t                   channel_o,
  output mac_addr_t                  mac_addr_o,
  output slot_time_t                 slot_time_o,
  output sifs_time_t                 sifs_time_o,
  output tsf_t                       tsf_runtime_val_o,
  output logic                       tsf_pulse_1m_o,
  output fc_di_t                     fc_di_o,
  output logic                       fc_di_valid_o,
  output mac_addr_t                  addr1_o,
  output logic                       addr1_valid_o,
  output mac_addr_t                  addr2_o,
  output logic                       addr2_valid_o,
  output mac_addr_t                  addr3_o,
  output logic                       addr3_valid_o,
  output logic                       pkt_for_me_o,
  output logic                       sig_valid_led_o,
  output logic                       demod_is_ongoing_led_o,
  output logic                       phy_tx_started_led_o
);

  tsf_t tsf_load_val;
  logic tsf_load_ctl;
  logic parse_soft_rst;
  logic parse_rst_n;
  logic sig_valid;

  // parser also cleared from software
  assign parse_rst_n = rst_n_i & ~parse_soft_rst;
  assign sig_valid   = pkt_header_valid_strobe_i & pkt_header_valid_i; // good signal field only

  xpu_regs xpu_regs_inst (
    .clk(clk), .rst_n_i(rst_n_i),
    .reg_wr_en_i(reg_wr_en_i), .reg_addr_i(reg_addr_i), .reg_wdata_i(reg_wdata_i),
    .tsf_runtime_val_i(tsf_runtime_val_o), .addr2_i(addr2_o),
    .reg_rdata_o(reg_rdata_o), .band_o(band_o), .channel_o(channel_o),
    .mac_addr_o(mac_addr_o), .slot_time_o(slot_time_o), .sifs_time_o(sifs_time_o),
    .tsf_load_val_o(tsf_load_val), .tsf_load_ctl_o(tsf_load_ctl),
    .parse_soft_rst_o(parse_soft_rst)
  );

  tsf_timer tsf_timer_inst (
    .clk(clk), .rst_n_i(rst_n_i),
    .tsf_load_ctl_i(tsf_load_ctl), .tsf_load_val_i(tsf_load_val),
    .tsf_runtime_val_o(tsf_runtime_val_o), .tsf_pulse_1m_o(tsf_pulse_1m_o)
  );

  phy_rx_parse phy_rx_parse_inst (
    .clk(clk), .rst_n_i(parse_rst_n),
    .byte_in_strobe_i(byte_in_strobe_i), .byte_i(byte_i), .byte_count_i(byte_count_i),
    .self_mac_addr_i(mac_addr_o),
    .fc_di_o(fc_di_o), .fc_di_valid_o(fc_di_valid_o),
    .addr1_o(addr1_o), .addr1_valid_o(addr1_valid_o),
    .addr2_o(addr2_o), .addr2_valid_o(addr2_valid_o),
    .addr3_o(addr3_o), .addr3_valid_o(addr3_valid_o),
    .pkt_for_me_o(pkt_for_me_o)
  );

  edge_to_flip sig_valid_flip (
    .clk(clk), .rst_n_i(rst_n_i), .data_i(sig_valid), .flip_o(sig_valid_led_o)
  );

  edge_to_flip demod_flip (
    .clk(clk), .rst_n_i(rst_n_i), .data_i(demod_is_ongoing_i), .flip_o(demod_is_ongoing_led_o)
  );

  edge_to_flip tx_started_flip (
    .clk(clk), .rst_n_i(rst_n_i), .data_i(phy_tx_started_i), .flip_o(phy_tx_started_led_o)
  );

endmodule

/* hw/xpu_lite_macros.svh */
// register map, clock rate and field positions for the lite xpu, include wherever indices are needed
`ifndef XPU_LITE_MACROS_SVH
`define XPU_LITE_MACROS_SVH

`define XPU_REG_ADDR_W 6
`define XPU_CLK_PER_US 100 // 100 MHz core clock
`define XPU_HW_VERSION 32'h5850_5501

// writable registers
`define XPU_REG_RST       6'd0
`define XPU_REG_TSF_LO    6'd2
`define XPU_REG_TSF_HI    6'd3 // msb rising edge triggers the load
`define XPU_REG_BAND      6'd4
`define XPU_REG_XIFS      6'd9
`define XPU_REG_MAC_LO    6'd30
`define XPU_REG_MAC_HI    6'd31

// read only registers
`define XPU_REG_TSF_RD_LO 6'd58
`define XPU_REG_TSF_RD_HI 6'd59
`define XPU_REG_ADDR2_RD  6'd62
`define XPU_REG_VERSION   6'd63

// bit positions inside registers
`define XPU_RST_PARSE_BIT 3
`define XPU_TSF_LOAD_BIT  31
`define XPU_BAND_ERP_BIT  24 // erp short slot
`define XPU_XIFS_OVR_BIT  31
`define XPU_BAND_2G4      4'd1

// byte offsets in the mac header
`define XPU_FC_OFS    0
`define XPU_ADDR1_OFS 4
`define XPU_ADDR2_OFS 10
`define XPU_ADDR3_OFS 16

`endif

/* hw/xpu_pkg.sv */
// shared types of the lite xpu, imported by the register bank, timer and header parser
package xpu_pkg;

  // station address as it appears in the header
  typedef logic [47:0] mac_addr_t;

  // frame control in 15:0, duration in 31:16
  typedef logic [31:0] fc_di_t;

  // 802.11 tsf in microseconds
  typedef logic [63:0] tsf_t;

  // one host register word
  typedef logic [31:0] reg_data_t;

  // slot time in us
  typedef logic [4:0] slot_time_t;

  // sifs in us
  typedef logic [6:0] sifs_time_t;

  // band code, 1 is 2.4GHz
  typedef logic [3:0] band_t;

  typedef logic [15:0] channel_t;

  // default slot and sifs per band
  localparam slot_time_t SLOT_LONG  = 5'd20;
  localparam slot_time_t SLOT_SHORT = 5'd9;
  localparam sifs_time_t SIFS_2G4   = 7'd10;
  localparam sifs_time_t SIFS_5G    = 7'd16;

endpackage

/* hw/xpu_regs.sv */
// host register bank of the lite xpu, holds config, muxes readback and derives slot and sifs
`include "xpu_lite_macros.svh"

module xpu_regs
  import xpu_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       reg_wr_en_i,
  input  logic [`XPU_REG_ADDR_W-1:0] reg_addr_i,
  input  reg_data_t                  reg_wdata_i,
  input  tsf_t                       tsf_runtime_val_i,
  input  mac_addr_t                  addr2_i,
  output reg_data_t                  reg_rdata_o,
  output band_t                      band_o,
  output channel_t                   channel_o,
  output mac_addr_t                  mac_addr_o,
  output slot_time_t                 slot_time_o,
  output sifs_time_t                 sifs_time_o,
  output tsf_t                       tsf_load_val_o,
  output logic                       tsf_load_ctl_o,
  output logic                       parse_soft_rst_o
);

  reg_data_t reg_rst_q;
  reg_data_t reg_tsf_lo_q;
  reg_data_t reg_tsf_hi_q;
  reg_data_t reg_band_q;   // 24 erp short slot, 19:16 band, 15:0 channel
  reg_data_t reg_xifs_q;   // 31 override, 18:14 slot, 13:7 sifs
  reg_data_t reg_mac_lo_q;
  reg_data_t reg_mac_hi_q; // only 15:0 form the address
  logic      erp_short_slot;
  logic      xifs_ovr;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      reg_rst_q    <= '0;
      reg_tsf_lo_q <= '0;
      reg_tsf_hi_q <= '0;
      reg_band_q   <= '0;
      reg_xifs_q   <= '0;
      reg_mac_lo_q <= '0;
      reg_mac_hi_q <= '0;
    end else if (reg_wr_en_i) begin
      case (reg_addr_i)
        `XPU_REG_RST:    reg_rst_q    <= reg_wdata_i;
        `XPU_REG_TSF_LO: reg_tsf_lo_q <= reg_wdata_i;
        `XPU_REG_TSF_HI: reg_tsf_hi_q <= reg_wdata_i;
        `XPU_REG_BAND:   reg_band_q   <= reg_wdata_i;
        `XPU_REG_XIFS:   reg_xifs_q   <= reg_wdata_i;
        `XPU_REG_MAC_LO: reg_mac_lo_q <= reg_wdata_i;
        `XPU_REG_MAC_HI: reg_mac_hi_q <= reg_wdata_i;
        default: ; // writes to read-only or unmapped slots are dropped
      endcase
    end
  end

  assign band_o         = reg_band_q[19:16];
  assign channel_o      = reg_band_q[15:0];
  assign mac_addr_o     = {reg_mac_hi_q[15:0], reg_mac_lo_q};
  assign erp_short_slot = reg_band_q[`XPU_BAND_ERP_BIT];
  assign xifs_ovr       = reg_xifs_q[`XPU_XIFS_OVR_BIT];

  // high word goes in whole, msb included
  assign tsf_load_val_o   = {reg_tsf_hi_q, reg_tsf_lo_q};
  assign tsf_load_ctl_o   = reg_tsf_hi_q[`XPU_TSF_LOAD_BIT];
  assign parse_soft_rst_o = reg_rst_q[`XPU_RST_PARSE_BIT];

  always_comb begin
    if (xifs_ovr) begin
      slot_time_o = reg_xifs_q[18:14];
      sifs_time_o = reg_xifs_q[13:7];
    end else if (band_o == `XPU_BAND_2G4) begin
      slot_time_o = erp_short_slot ? SLOT_SHORT : SLOT_LONG;
      sifs_time_o = SIFS_2G4;
    end else begin
      slot_time_o = SLOT_SHORT; // ofdm bands always short
      sifs_time_o = SIFS_5G;
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      `XPU_REG_RST:       reg_rdata_o = reg_rst_q;
      `XPU_REG_TSF_LO:    reg_rdata_o = reg_tsf_lo_q;
      `XPU_REG_TSF_HI:    reg_rdata_o = reg_tsf_hi_q;
      `XPU_REG_BAND:      reg_rdata_o = reg_band_q;
      `XPU_REG_XIFS:      reg_rdata_o = reg_xifs_q;
      `XPU_REG_MAC_LO:    reg_rdata_o = reg_mac_lo_q;
      `XPU_REG_MAC_HI:    reg_rdata_o = reg_mac_hi_q;
      `XPU_REG_TSF_RD_LO: reg_rdata_o = tsf_runtime_val_i[31:0];
      `XPU_REG_TSF_RD_HI: reg_rdata_o = tsf_runtime_val_i[63:32];
      // byte order as the driver expects when filling addr fields
      `XPU_REG_ADDR2_RD:  reg_rdata_o = {addr2_i[23:16], addr2_i[31:24],
                                         addr2_i[39:32], addr2_i[47:40]};
      `XPU_REG_VERSION:   reg_rdata_o = `XPU_HW_VERSION;
      default:            reg_rdata_o = '0;
    endcase
  end

endmodule

/* tb/xpu_lite_tb.sv */
// self-checking testbench for xpu_lite, compile with the project file list and run xpu_lite_tb
`include "xpu_lite_macros.svh"

module xpu_lite_tb
  import xpu_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 100;
  localparam int N_FRAMES    = 32;
  localparam int N_PULSES    = 48;
  // reset, register and timing writes, tsf wait, frames, led pulses
  localparam int TEST_CYCLES = 4 + 80 + 1100 + N_FRAMES * 64 + N_PULSES * 8;

  logic                       clk = 1'b0;
  logic                       rst_n_i;
  logic                       reg_wr_en_i;
  logic [`XPU_REG_ADDR_W-1:0] reg_addr_i;
  reg_data_t                  reg_wdata_i;
  logic                       byte_in_strobe_i;
  logic [7:0]                 byte_i;
  logic [15:0]                byte_count_i;
  logic                       pkt_header_valid_i;
  logic                       pkt_header_valid_strobe_i;
  logic                       demod_is_ongoing_i;
  logic                       phy_tx_started_i;
  reg_data_t                  reg_rdata_o;
  band_t                      band_o;
  channel_t                   channel_o;
  mac_addr_t                  mac_addr_o;
  slot_time_t                 slot_time_o;
  sifs_time_t                 sifs_time_o;
  tsf_t                       tsf_runtime_val_o;
  logic                       tsf_pulse_1m_o;
  fc_di_t                     fc_di_o;
  logic                       fc_di_valid_o;
  mac_addr_t                  addr1_o;
  logic                       addr1_valid_o;
  mac_addr_t                  addr2_o;
  logic                       addr2_valid_o;
  mac_addr_t                  addr3_o;
  logic                       addr3_valid_o;
  logic                       pkt_for_me_o;
  logic                       sig_valid_led_o;
  logic                       demod_is_ongoing_led_o;
  logic                       phy_tx_started_led_o;

  logic [31:0] lfsr = 32'h4f908de6;
  logic [7:0]  hdr [24]; // header bytes of the frame in flight
  mac_addr_t   mac;
  logic [63:0] fc_q[$];  // expected fields, one entry per frame
  logic [63:0] a1_q[$];
  logic [63:0] a2_q[$];
  logic [63:0] a3_q[$];
  logic [63:0] me_q[$];

  xpu_lite xpu_lite_inst (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  // {slot, sifs} from the band register and the xifs register
  function automatic logic [11:0] exp_times(input logic [31:0] band_reg, input logic [31:0] xifs);
    if (xifs[31]) return {xifs[18:14], xifs[13:7]};
    if (band_reg[19:16] == 4'd1) return {(band_reg[24] ? 5'd9 : 5'd20), 7'd10};
    return {5'd9, 7'd16};
  endfunction

  function automatic logic [63:0] le_field(input logic [7:0] h [24], input int ofs, input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) v[8 * k +: 8] = h[ofs + k]; // byte k lands at bits 8k+7:8k
    return v;
  endfunction

  task automatic fail_msg(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("** Error %s: expected %0h, actual %0h", name, exp, act);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else fail_value(name, exp, act);
  endtask

  task automatic reg_write(input logic [5:0] addr, input logic [31:0] data);
    @(posedge clk);
    reg_wr_en_i <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    @(posedge clk);
    reg_wr_en_i <= 1'b0;
  endtask

  task automatic reg_read(input logic [5:0] addr, output logic [31:0] data);
    @(posedge clk);
    reg_addr_i <= addr;
    @(negedge clk);
    data = reg_rdata_o; // combinational readback, settled by now
  endtask

  task automatic read_tsf(output logic [63:0] t);
    logic [31:0] lo;
    logic [31:0] hi;
    reg_read(`XPU_REG_TSF_RD_LO, lo);
    reg_read(`XPU_REG_TSF_RD_HI, hi);
    t = {hi, lo};
  endtask

  task automatic check_times(input logic [31:0] band_reg, input logic [31:0] xifs);
    reg_write(`XPU_REG_BAND, band_reg);
    reg_write(`XPU_REG_XIFS, xifs);
    @(negedge clk);
    check_eq("slot_sifs", 64'(exp_times(band_reg, xifs)), 64'({slot_time_o, sifs_time_o}));
  endtask

  task automatic send_frame();
    for (int k = 0; k < 24; k++) begin
      @(posedge clk);
      byte_in_strobe_i <= 1'b1;
      byte_i           <= hdr[k];
      byte_count_i     <= 16'(k);
      if (rand_bits(1) != '0) begin
        @(posedge clk); // idle cycle between bytes
        byte_in_strobe_i <= 1'b0;
      end
    end
    @(posedge clk);
    byte_in_strobe_i <= 1'b0;
  endtask

  task automatic pulse_source(input logic [1:0] src, input int len);
    @(posedge clk);
    case (src)
      2'd0: begin
        pkt_header_valid_strobe_i <= 1'b1;
        pkt_header_valid_i        <= 1'b1;
      end
      2'd1: pkt_header_valid_strobe_i <= 1'b1; // bad signal field
      2'd2: demod_is_ongoing_i <= 1'b1;
      default: phy_tx_started_i <= 1'b1;
    endcase
    repeat (len) @(posedge clk);
    pkt_header_valid_strobe_i <= 1'b0;
    pkt_header_valid_i        <= 1'b0;
    demod_is_ongoing_i        <= 1'b0;
    phy_tx_started_i          <= 1'b0;
  endtask

  // compares each parser field as its valid pulses
  always @(negedge clk) begin
    if (fc_di_valid_o) begin
      if (fc_q.size() == 0) fail_msg("fc_di_valid_o pulsed with no frame pending");
      else check_eq("fc_di", fc_q.pop_front(), 64'(fc_di_o));
    end
    if (addr1_valid_o) begin
      if (a1_q.size() == 0) fail_msg("addr1_valid_o pulsed with no frame pending");
      else begin
        check_eq("addr1", a1_q.pop_front(), 64'(addr1_o));
        check_eq("pkt_for_me", me_q.pop_front(), 64'(pkt_for_me_o));
      end
    end
    if (addr2_valid_o) begin
      if (a2_q.size() == 0) fail_msg("addr2_valid_o pulsed with no frame pending");
      else check_eq("addr2", a2_q.pop_front(), 64'(addr2_o));
    end
    if (addr3_valid_o) begin
      if (a3_q.size() == 0) fail_msg("addr3_valid_o pulsed with no frame pending");
      else check_eq("addr3", a3_q.pop_front(), 64'(addr3_o));
    end
  end

  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    fail_msg("watchdog timeout, the tests did not finish in time");
  end

  initial begin
    logic [31:0] band_reg;
    logic [31:0] rd;
    logic [63:0] tsf_load;
    logic [63:0] t1;
    logic [63:0] t2;
    logic [1:0]  kind;
    int          sv_cnt;
    int          demod_cnt;
    int          tx_cnt;
    int          n_pulse;
    int          gap;
    rst_n_i                   = 1'b0;
    reg_wr_en_i               = 1'b0;
    reg_addr_i                = '0;
    reg_wdata_i               = '0;
    byte_in_strobe_i          = 1'b0;
    byte_i                    = '0;
    byte_count_i              = '0;
    pkt_header_valid_i        = 1'b0;
    pkt_header_valid_strobe_i = 1'b0;
    demod_is_ongoing_i        = 1'b0;
    phy_tx_started_i          = 1'b0;
    sv_cnt                    = 0;
    demod_cnt                 = 0;
    tx_cnt                    = 0;
    n_pulse                   = 0;
    gap                       = 0;
    repeat (4) @(posedge clk);
    rst_n_i <= 1'b1;

    // register writes and version
    band_reg = {12'h0, 4'd1, 16'(rand_bits(16))};
    mac      = 48'(rand_bits(48));
    reg_write(`XPU_REG_BAND, band_reg);
    reg_write(`XPU_REG_MAC_LO, mac[31:0]);
    reg_write(`XPU_REG_MAC_HI, {16'(rand_bits(16)), mac[47:32]}); // top half ignored
    @(negedge clk);
    check_eq("band", 64'(band_reg[19:16]), 64'(band_o));
    check_eq("channel", 64'(band_reg[15:0]), 64'(channel_o));
    check_eq("mac_addr", 64'(mac), 64'(mac_addr_o));
    reg_read(`XPU_REG_VERSION, rd);
    check_eq("version", 64'(`XPU_HW_VERSION), 64'(rd));

    // slot and sifs per band, then with override
    check_times({12'h0, 4'd1, 16'd6}, 32'h0);
    check_times({7'h0, 1'b1, 4'h0, 4'd1, 16'd11}, 32'h0);
    check_times({12'h0, 4'd2, 16'd36}, 32'h0);
    check_times({12'h0, 4'd2, 16'd36}, {1'b1, 31'(rand_bits(31))});
    check_times({7'h0, 1'b1, 4'h0, 4'd1, 16'd1}, {1'b1, 31'(rand_bits(31))});

    // tsf load, 1000 cycles is 10 us at 100 clocks per us
    tsf_load = {1'b1, 63'(rand_bits(63))};
    reg_write(`XPU_REG_TSF_LO, tsf_load[31:0]);
    reg_write(`XPU_REG_TSF_HI, tsf_load[63:32]);
    read_tsf(t1);
    for (int c = 0; c < 1000; c++) begin
      @(negedge clk);
      gap++;
      if (tsf_pulse_1m_o) begin
        n_pulse++;
        if (n_pulse > 1) check_eq("pulse_gap", 64'(`XPU_CLK_PER_US), 64'(gap));
        check_eq("tsf_runtime", t1 + 64'(n_pulse), tsf_runtime_val_o); // one step per pulse
        gap = 0;
      end
    end
    assert (n_pulse >= 9 && n_pulse <= 11)
      else fail_value("pulse_count", 64'd10, 64'(n_pulse));
    read_tsf(t2);
    assert (t1 >= tsf_load && t1 - tsf_load <= 64'd1) else fail_value("tsf_load", tsf_load, t1);
    assert (t2 - t1 >= 64'd9 && t2 - t1 <= 64'd11) else fail_value("tsf_count", 64'd10, t2 - t1);

    // header parse, kind 0/1 hit our address, 2 misses by one byte, 3 is random
    for (int f = 0; f < N_FRAMES; f++) begin
      for (int k = 0; k < 24; k++) hdr[k] = 8'(rand_bits(8));
      kind = 2'(rand_bits(2));
      if (kind != 2'd3) begin
        for (int k = 0; k < 6; k++) hdr[`XPU_ADDR1_OFS + k] = mac[8 * k +: 8];
      end
      if (kind == 2'd2) hdr[`XPU_ADDR1_OFS + 5 - f % 6] ^= 8'h10;
      fc_q.push_back(le_field(hdr, `XPU_FC_OFS, 4));
      a1_q.push_back(le_field(hdr, `XPU_ADDR1_OFS, 6));
      a2_q.push_back(le_field(hdr, `XPU_ADDR2_OFS, 6));
      a3_q.push_back(le_field(hdr, `XPU_ADDR3_OFS, 6));
      me_q.push_back(64'(le_field(hdr, `XPU_ADDR1_OFS, 6) == 64'(mac)));
      send_frame();
      repeat (3) @(negedge clk);
      assert (fc_q.size() + a1_q.size() + a2_q.size() + a3_q.size() + me_q.size() == 0)
        else fail_msg("a header field valid did not pulse for the frame");
      reg_read(`XPU_REG_ADDR2_RD, rd);
      // addr2 bytes 2 to 5 as streamed, byte 2 on top
      check_eq("addr2_rd", 64'({hdr[`XPU_ADDR2_OFS + 2], hdr[`XPU_ADDR2_OFS + 3],
                                hdr[`XPU_ADDR2_OFS + 4], hdr[`XPU_ADDR2_OFS + 5]}), 64'(rd));
    end

    // led toggling, parity of rising edges per source
    for (int p = 0; p < N_PULSES; p++) begin
      kind = 2'(rand_bits(2));
      pulse_source(kind, 1 + int'(rand_bits(2)));
      if (kind == 2'd0) sv_cnt++;
      if (kind == 2'd2) demod_cnt++;
      if (kind == 2'd3) tx_cnt++;
    end
    repeat (3) @(negedge clk);
    check_eq("sig_valid_led", 64'(sv_cnt[0]), 64'(sig_valid_led_o));
    check_eq("demod_led", 64'(demod_cnt[0]), 64'(demod_is_ongoing_led_o));
    check_eq("tx_started_led", 64'(tx_cnt[0]), 64'(phy_tx_started_led_o));

    $display("Regression passed");
    $finish;
  end

endmodule

/* xpu_lite.f */
+incdir+hw
hw/xpu_pkg.sv
hw/edge_to_flip.sv
hw/field_capture.sv
hw/tsf_timer.sv
hw/phy_rx_parse.sv
hw/xpu_regs.sv
hw/xpu_lite.sv
tb/xpu_lite_tb.sv
